/* hdl/ship_pkg.sv */
`default_nettype none

package ship_pkg;

	//////////////////////////////////////////////////
	// Coordinate types
	//////////////////////////////////////////////////

	localparam int COORD_W = 10;

	// Screen coordinate, x or y
	typedef logic [COORD_W-1:0] coord_t;

	// One spare bit so that sums of a coordinate and a half size never wrap
	typedef logic [COORD_W:0] coord_ext_t;

	// Number of alien targets tested by the bolt
	localparam int NUM_ALIENS = 3;

	// One coordinate per alien, alien 0 in the low word
	typedef coord_t [NUM_ALIENS-1:0] alien_coords_t;

	// Game mode, anything but MODE_PLAY is a menu screen
	typedef logic [1:0] mode_t;
	localparam mode_t MODE_PLAY = 2'd2;

	//////////////////////////////////////////////////
	// Geometry
	//////////////////////////////////////////////////

	// Screen and scoreboard limits
	localparam coord_t SCREEN_WIDTH      = 10'd640;
	localparam coord_t SCOREBOARD_BOTTOM = 10'd40;

	// Ship rows and half length
	localparam coord_t SHIP_TOP      = 10'd420;
	localparam coord_t SHIP_BOTTOM   = 10'd430;
	localparam coord_t SHIP_HALF_LEN = 10'd20;
	localparam coord_t SHIP_START_X  = 10'd320;

	// Ship centre travel range
	localparam coord_t SHIP_MIN_X = SHIP_HALF_LEN;
	localparam coord_t SHIP_MAX_X = SCREEN_WIDTH - SHIP_HALF_LEN;

	// Bolt rest row and half sizes
	localparam coord_t LASER_START_Y     = 10'd417;
	localparam coord_t LASER_HALF_HEIGHT = 10'd5;
	localparam coord_t LASER_HALF_LEN    = 10'd1;

	// Target half sizes
	localparam coord_t SAUCER_HALF_HEIGHT = 10'd7;
	localparam coord_t SAUCER_HALF_LEN    = 10'd20;
	localparam coord_t ALIEN_HALF_HEIGHT  = 10'd8;
	localparam coord_t ALIEN_HALF_LEN     = 10'd15;

	// Movement per frame, ship and bolt alike
	localparam coord_t STEP = 10'd1;

	// Zero extension for wrap-free compares
	function automatic coord_ext_t ext(input coord_t c);
		return {1'b0, c};
	endfunction

endpackage

`default_nettype wire

/* hdl/player_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module player_ctrl import ship_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire logic   restart,
	input  wire mode_t  mode,
	input  wire logic   button_left,
	input  wire logic   button_right,
	input  wire logic   button_shoot,
	input  wire coord_t scan_x,
	input  wire coord_t scan_y,
	input  wire logic   laser_hit_now,
	output coord_t      ship_x,
	output coord_t      laser_x,
	output coord_t      laser_y,
	output logic        laser_active
);

	// Bolt rests on the ship or climbs the screen
	typedef enum logic {
		BOLT_IDLE = 1'b0,
		BOLT_FLY  = 1'b1
	} bolt_state_t;

	bolt_state_t bolt_state;

	logic frame_tick;
	logic in_play;
	logic move_right;
	logic move_left;

	//////////////////////////////////////////////////
	// Frame tick and mode gating
	//////////////////////////////////////////////////

	// Scan at the top left pixel marks a new frame
	assign frame_tick = (scan_x == '0) && (scan_y == '0);

	// Menus and restart hold everything at start values
	assign in_play = (mode == MODE_PLAY) && !restart;

	// Moves allowed only inside the edge limits
	assign move_right = button_right && (ship_x < SHIP_MAX_X);
	assign move_left  = button_left && (ship_x > SHIP_MIN_X);

	//////////////////////////////////////////////////
	// Ship position
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ship_x <= SHIP_START_X;
		end else if (!in_play) begin
			ship_x <= SHIP_START_X;
		end else if (frame_tick) begin
			// Right takes priority when both are held
			if (move_right) begin
				ship_x <= ship_x + STEP;
			end else if (move_left) begin
				ship_x <= ship_x - STEP;
			end
		end
	end

	//////////////////////////////////////////////////
	// Bolt state machine
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bolt_state <= BOLT_IDLE;
			laser_x    <= SHIP_START_X;
			laser_y    <= LASER_START_Y;
		end else if (!in_play) begin
			bolt_state <= BOLT_IDLE;
			laser_x    <= SHIP_START_X;
			laser_y    <= LASER_START_Y;
		end else if (frame_tick) begin
			case (bolt_state)
				BOLT_IDLE: begin
					// Launch from the ship centre
					if (button_shoot) begin
						bolt_state <= BOLT_FLY;
						laser_x    <= ship_x;
						laser_y    <= LASER_START_Y;
					end
				end
				BOLT_FLY: begin
					// Shoot is ignored in flight
					if (laser_hit_now) begin
						// Back to the ship, wherever it is now
						bolt_state <= BOLT_IDLE;
						laser_x    <= ship_x;
						laser_y    <= LASER_START_Y;
					end else begin
						// One line up per frame
						laser_y <= laser_y - STEP;
					end
				end
				default: begin
					bolt_state <= BOLT_IDLE;
				end
			endcase
		end
	end

	// Hit result only matters while flying
	assign laser_active = (bolt_state == BOLT_FLY);

endmodule

`default_nettype wire

/* hdl/laser_hit.sv */
`timescale 1ns/10ps
`default_nettype none

module laser_hit import ship_pkg::*; (
	input  wire coord_t        laser_x,
	input  wire coord_t        laser_y,
	input  wire coord_t        saucer_x,
	input  wire coord_t        saucer_y,
	input  wire alien_coords_t alien_x,
	input  wire alien_coords_t alien_y,
	output logic               laser_hit_now
);

	logic                  board_hit;
	logic                  saucer_hit;
	logic [NUM_ALIENS-1:0] alien_hit;

	//////////////////////////////////////////////////
	// Box test
	//////////////////////////////////////////////////

	// Bolt at or below the target's lower edge plus one step,
	// and bolt x inside the target's horizontal span
	function automatic logic box_hit(
		input coord_t lx,
		input coord_t ly,
		input coord_t tx,
		input coord_t ty,
		input coord_t half_h,
		input coord_t half_l
	);
		logic y_ok;
		logic x_lo_ok;
		logic x_hi_ok;
		y_ok    = ext(ly) <= ext(ty) + ext(half_h) + ext(STEP);
		// Left bound moved to the bolt side, no subtraction
		x_lo_ok = ext(lx) + ext(half_l) >= ext(tx);
		x_hi_ok = ext(lx) <= ext(tx) + ext(half_l);
		return y_ok && x_lo_ok && x_hi_ok;
	endfunction

	//////////////////////////////////////////////////
	// Targets
	//////////////////////////////////////////////////

	// Scoreboard edge, constant sum fits in a coordinate
	assign board_hit = laser_y <= SCOREBOARD_BOTTOM + LASER_HALF_HEIGHT + STEP;

	// Flying saucer
	assign saucer_hit = box_hit(laser_x, laser_y, saucer_x, saucer_y,
				SAUCER_HALF_HEIGHT, SAUCER_HALF_LEN);

	// Each alien with the same test
	always_comb begin
		alien_hit = '0;
		for (int i = 0; i < NUM_ALIENS; i++) begin
			alien_hit[i] = box_hit(laser_x, laser_y, alien_x[i], alien_y[i],
					ALIEN_HALF_HEIGHT, ALIEN_HALF_LEN);
		end
	end

	// Any overlap sends the bolt home
	assign laser_hit_now = board_hit || saucer_hit || (|alien_hit);

endmodule

`default_nettype wire

/* hdl/sprite_pixel.sv */
`timescale 1ns/10ps
`default_nettype none

module sprite_pixel import ship_pkg::*; (
	input  wire coord_t scan_x,
	input  wire coord_t scan_y,
	input  wire coord_t ship_x,
	input  wire coord_t laser_x,
	input  wire coord_t laser_y,
	output logic        is_ship,
	output logic        is_laser
);

	logic ship_rows;
	logic ship_cols;
	logic laser_rows;
	logic laser_cols;

	//////////////////////////////////////////////////
	// Ship box
	//////////////////////////////////////////////////

	// Fixed rows
	assign ship_rows = (scan_y >= SHIP_TOP) && (scan_y <= SHIP_BOTTOM);

	// Centre plus or minus half length
	assign ship_cols = (ext(scan_x) + ext(SHIP_HALF_LEN) >= ext(ship_x))
			&& (ext(scan_x) <= ext(ship_x) + ext(SHIP_HALF_LEN));

	assign is_ship = ship_rows && ship_cols;

	//////////////////////////////////////////////////
	// Bolt box
	//////////////////////////////////////////////////

	// Vertical span around the bolt centre
	assign laser_rows = (ext(scan_y) + ext(LASER_HALF_HEIGHT) >= ext(laser_y))
			&& (ext(scan_y) <= ext(laser_y) + ext(LASER_HALF_HEIGHT));

	// Three pixels wide
	assign laser_cols = (ext(scan_x) + ext(LASER_HALF_LEN) >= ext(laser_x))
			&& (ext(scan_x) <= ext(laser_x) + ext(LASER_HALF_LEN));

	// Drawn at rest too, sitting on the ship
	assign is_laser = laser_rows && laser_cols;

endmodule

`default_nettype wire

/* hdl/spaceship_top.sv */
`timescale 1ns/10ps
`default_nettype none

module spaceship_top import ship_pkg::*; (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          restart,
	input  wire mode_t         mode,
	input  wire logic          button_left,
	input  wire logic          button_right,
	input  wire logic          button_shoot,
	input  wire coord_t        scan_x,
	input  wire coord_t        scan_y,
	input  wire coord_t        saucer_x,
	input  wire coord_t        saucer_y,
	input  wire alien_coords_t alien_x,
	input  wire alien_coords_t alien_y,
	output wire logic          is_ship,
	output wire logic          is_laser,
	output wire coord_t        laser_x,
	output wire coord_t        laser_y
);

	// Ship centre, shared by controller and pixel logic
	coord_t ship_x;

	// Overlap result fed back to the bolt FSM
	logic laser_hit_now;

	//////////////////////////////////////////////////
	// Controller
	//////////////////////////////////////////////////

	player_ctrl player_ctrl_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.restart       (restart),
		.mode          (mode),
		.button_left   (button_left),
		.button_right  (button_right),
		.button_shoot  (button_shoot),
		.scan_x        (scan_x),
		.scan_y        (scan_y),
		.laser_hit_now (laser_hit_now),
		.ship_x        (ship_x),
		.laser_x       (laser_x),
		.laser_y       (laser_y),
		.laser_active  ()
	);

	//////////////////////////////////////////////////
	// Collision and pixel flags
	//////////////////////////////////////////////////

	laser_hit laser_hit_i (
		.laser_x       (laser_x),
		.laser_y       (laser_y),
		.saucer_x      (saucer_x),
		.saucer_y      (saucer_y),
		.alien_x       (alien_x),
		.alien_y       (alien_y),
		.laser_hit_now (laser_hit_now)
	);

	// Same-cycle flags for the pixel mixer
	sprite_pixel sprite_pixel_i (
		.scan_x   (scan_x),
		.scan_y   (scan_y),
		.ship_x   (ship_x),
		.laser_x  (laser_x),
		.laser_y  (laser_y),
		.is_ship  (is_ship),
		.is_laser (is_laser)
	);

endmodule

`default_nettype wire

/* test/spaceship_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module spaceship_assertions import ship_pkg::*; (
	input wire logic   clk,
	input wire logic   rst_n,
	input wire coord_t ship_x,
	input wire coord_t laser_y,
	input wire logic   laser_active
);

	//////////////////////////////////////////////////
	// Player state invariants
	//////////////////////////////////////////////////

	// Ship centre stays inside its travel range
	ship_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		(ship_x >= SHIP_MIN_X) && (ship_x <= SHIP_MAX_X))
		else $error("ship_x left its travel range");

	// Resting bolt sits on the launch row
	bolt_at_rest: assert property (@(posedge clk) disable iff (!rst_n)
		!laser_active |-> (laser_y == LASER_START_Y))
		else $error("inactive bolt is not at the launch row");

	// A flying bolt only climbs, or drops back to rest
	bolt_climbs: assert property (@(posedge clk) disable iff (!rst_n)
		laser_active |=> !laser_active || (laser_y <= $past(laser_y)))
		else $error("active bolt moved down the screen");

endmodule

`default_nettype wire

/* test/spaceship_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module spaceship_tb import ship_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int RUN_CYCLES = 4000;
	// Run length plus a quarter
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;

	logic          clk;
	logic          rst_n;
	logic          restart;
	mode_t         mode;
	logic          button_left;
	logic          button_right;
	logic          button_shoot;
	coord_t        scan_x;
	coord_t        scan_y;
	coord_t        saucer_x;
	coord_t        saucer_y;
	alien_coords_t alien_x;
	alien_coords_t alien_y;
	logic          is_ship;
	logic          is_laser;
	coord_t        laser_x;
	coord_t        laser_y;

	// Reference model state, plain integers
	int   m_ship_x;
	int   m_laser_x;
	int   m_laser_y;
	logic m_active;

	logic [31:0] lcg_state;
	int          cycle_count = 0;
	int          error_count = 0;

	spaceship_top spaceship_top_i (.*);

	bind player_ctrl spaceship_assertions spaceship_assertions_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.ship_x       (ship_x),
		.laser_y      (laser_y),
		.laser_active (laser_active)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	//////////////////////////////////////////////////
	// Random numbers and failure reporting
	//////////////////////////////////////////////////

	function automatic int unsigned random_below(input int unsigned n);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {17'd0, lcg_state[30:16]} % n;
	endfunction

	task automatic report_failure(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_coord(input string name, input coord_t actual, input coord_t expected);
		if (actual !== expected) begin
			report_failure($sformatf("mismatch at %0t: %s is %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
				$time, name, actual, expected));
		end
	endtask

	// Hard stop if the main loop never finishes
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			report_failure($sformatf("timeout: run still going after %0d cycles",
				cycle_count));
		end
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic target_overlap(input int lx, input int ly, input int tx,
		input int ty, input int half_h, input int half_l);
		return (ly <= ty + half_h + int'(STEP)) && (lx >= tx - half_l) && (lx <= tx + half_l);
	endfunction

	function automatic logic bolt_hits(input int lx, input int ly);
		logic hit;
		hit = ly <= int'(SCOREBOARD_BOTTOM) + int'(LASER_HALF_HEIGHT) + int'(STEP);
		hit = hit || target_overlap(lx, ly, int'(saucer_x), int'(saucer_y),
			int'(SAUCER_HALF_HEIGHT), int'(SAUCER_HALF_LEN));
		for (int i = 0; i < NUM_ALIENS; i++) begin
			hit = hit || target_overlap(lx, ly, int'(alien_x[i]), int'(alien_y[i]),
				int'(ALIEN_HALF_HEIGHT), int'(ALIEN_HALF_LEN));
		end
		return hit;
	endfunction

	function automatic logic in_ship_box(input int sx, input int sy);
		return (sy >= int'(SHIP_TOP)) && (sy <= int'(SHIP_BOTTOM))
			&& (sx >= m_ship_x - int'(SHIP_HALF_LEN)) && (sx <= m_ship_x + int'(SHIP_HALF_LEN));
	endfunction

	function automatic logic in_laser_box(input int sx, input int sy);
		return (sy >= m_laser_y - int'(LASER_HALF_HEIGHT))
			&& (sy <= m_laser_y + int'(LASER_HALF_HEIGHT))
			&& (sx >= m_laser_x - int'(LASER_HALF_LEN)) && (sx <= m_laser_x + int'(LASER_HALF_LEN));
	endfunction

	task automatic reset_model();
		m_ship_x  = int'(SHIP_START_X);
		m_laser_x = int'(SHIP_START_X);
		m_laser_y = int'(LASER_START_Y);
		m_active  = 1'b0;
	endtask

	// Same edge as the DUT, inputs still hold last cycle's values
	task automatic update_model();
		logic hit;
		if (mode != MODE_PLAY || restart) begin
			reset_model();
		end else if (scan_x == '0 && scan_y == '0) begin
			hit = bolt_hits(m_laser_x, m_laser_y);
			// Bolt first, it takes the old ship position
			if (!m_active && button_shoot) begin
				m_active  = 1'b1;
				m_laser_x = m_ship_x;
				m_laser_y = int'(LASER_START_Y);
			end else if (m_active && hit) begin
				m_active  = 1'b0;
				m_laser_x = m_ship_x;
				m_laser_y = int'(LASER_START_Y);
			end else if (m_active) begin
				m_laser_y = m_laser_y - int'(STEP);
			end
			if (button_right && m_ship_x < int'(SCREEN_WIDTH) - int'(SHIP_HALF_LEN)) begin
				m_ship_x = m_ship_x + int'(STEP);
			end else if (button_left && m_ship_x > int'(SHIP_HALF_LEN)) begin
				m_ship_x = m_ship_x - int'(STEP);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Target x from x_lo up to the right screen limit
	task automatic place_targets(input int x_lo);
		alien_coords_t ax;
		alien_coords_t ay;
		for (int i = 0; i < NUM_ALIENS; i++) begin
			ax[i] = coord_t'(x_lo + random_below(620 - x_lo));
			ay[i] = coord_t'(50 + random_below(251));
		end
		saucer_x <= coord_t'(x_lo + random_below(620 - x_lo));
		saucer_y <= coord_t'(50 + random_below(251));
		alien_x  <= ax;
		alien_y  <= ay;
	endtask

	task automatic drive_inputs(input int cyc);
		int unsigned pick;
		pick = random_below(4);
		// Left hold keeps targets right of the bolt column, bolt climbs to the scoreboard
		if (cyc % 200 == 0) begin
			place_targets((cyc >= 1400 && cyc < 2920) ? 380 : 20);
		end
		// Frame tick every fourth cycle, else aim near ship, near bolt or anywhere
		if (cyc % 4 == 0) begin
			scan_x <= '0;
			scan_y <= '0;
		end else if (pick == 0) begin
			scan_x <= coord_t'(m_ship_x - 24 + int'(random_below(49)));
			scan_y <= coord_t'(418 + random_below(15));
		end else if (pick == 1) begin
			scan_x <= coord_t'(m_laser_x - 3 + int'(random_below(7)));
			scan_y <= coord_t'(m_laser_y - 7 + int'(random_below(15)));
		end else begin
			scan_x <= coord_t'(random_below(640));
			scan_y <= coord_t'(random_below(480));
		end
		// Long right hold, menu gap, long left hold, restart, then free play
		if ((cyc >= 1400 && cyc < 1410) || (cyc >= 2930 && random_below(200) == 0)) begin
			mode <= (random_below(3) == 0) ? 2'd0 : (random_below(2) == 0) ? 2'd1 : 2'd3;
		end else begin
			mode <= MODE_PLAY;
		end
		restart <= (cyc >= 2920 && cyc < 2925) || (cyc >= 2930 && random_below(300) == 0);
		if (cyc < 1410) begin
			button_right <= 1'b1;
			button_left  <= (random_below(8) == 0);
			button_shoot <= (random_below(4) == 0);
		end else if (cyc < 2920) begin
			// Shoot held, launch on the first frame and relaunch right after return
			button_right <= 1'b0;
			button_left  <= 1'b1;
			button_shoot <= 1'b1;
		end else begin
			button_right <= (random_below(2) == 0);
			button_left  <= (random_below(2) == 0);
			button_shoot <= (random_below(4) == 0);
		end
	endtask

	task automatic check_outputs();
		check_coord("laser_x", laser_x, coord_t'(m_laser_x));
		check_coord("laser_y", laser_y, coord_t'(m_laser_y));
		check_flag("is_ship", is_ship, in_ship_box(int'(scan_x), int'(scan_y)));
		check_flag("is_laser", is_laser, in_laser_box(int'(scan_x), int'(scan_y)));
	endtask

	initial begin
		lcg_state    = 32'd23;
		rst_n        = 1'b0;
		restart      = 1'b0;
		mode         = MODE_PLAY;
		button_left  = 1'b0;
		button_right = 1'b0;
		button_shoot = 1'b0;
		scan_x       = 10'd1;
		scan_y       = 10'd1;
		saucer_x     = 10'd320;
		saucer_y     = 10'd100;
		alien_x      = '0;
		alien_y      = '0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_outputs();
		for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
			@(posedge clk);
			update_model();
			drive_inputs(cyc);
			// Outputs settled by the falling edge
			@(negedge clk);
			check_outputs();
		end
		if (error_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			report_failure($sformatf("%0d checks failed", error_count));
		end
	end

endmodule

`default_nettype wire

/* list.f */
hdl/ship_pkg.sv
hdl/player_ctrl.sv
hdl/laser_hit.sv
hdl/sprite_pixel.sv
hdl/spaceship_top.sv
test/spaceship_assertions.sv
test/spaceship_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module spaceship_tb \
	-f list.f -o spaceship_sim &&
./obj_dir/spaceship_sim > sim.log 2>&1 &&
! grep -q "Test failures found" sim.log &&
echo "simulation passed" ||
{ cat sim.log; echo "simulation failed"; exit 1; }
